// File: mmu_bus_pkg.sv
`default_nettype none

package mmu_bus_pkg;

   typedef enum logic [1:0] {
      PRIV_U = 2'b00,
      PRIV_S = 2'b01,
      PRIV_M = 2'b11
   } priv_e;

   // same layout on both cpu ports and on the bus
   typedef struct packed {
      logic        write;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
   } cpu_cmd_t;

   typedef struct packed {
      logic [31:0] data;
      logic        fault;
      logic [4:0]  exc_code;
      logic [31:0] tval;
   } cpu_resp_t;

   // data_priv is the mode after MPRV
   typedef struct packed {
      logic        satp_mode;
      logic [21:0] satp_ppn;
      priv_e       fetch_priv;
      priv_e       data_priv;
      logic        sum;
      logic        mxr;
   } mmu_csr_t;

endpackage

`default_nettype wire

// File: mmu_testdata.txt
// satp_ppn, page-table word count, then address/word pairs, request count, then per
// request: ctrl vaddr wdata paddr expect; ctrl nibbles port write flush mode fpriv dpriv sum mxr
// port 0 fetch, 1 data, 2 fetch raised with the next data line; expect [15:8] trans [7:0] code
00000010
00000011
00010004 00004401  00010008 0C0000CF  0001000C 0C0004CF
00011000 080000CF  00011004 080004CF  00011008 080008CF  0001100C 08000CCF
00011010 080010CF  00011014 080014CF  00011018 080018CF  0001101C 08001CCF
00011020 00000000  00011024 080024D7  00011028 08002849  0001102C 08002C47
00011030 08003087  00011034 080034C7
0000001A
10000110 12345678 00000000 12345678 00000100
10013300 00400010 00000000 00400010 00000100
10011100 00400ABC 00000000 20000ABC 00000300
10011100 00400124 00000000 20000124 00000100
10011100 00812344 00000000 30012344 00000200
10011100 00C00000 00000000 00000000 0000010D
10011100 00408000 00000000 00000000 0000020D
10011100 00409000 00000000 00000000 0000020D
10011110 00409000 00000000 20009000 00000300
10011100 0040A000 00000000 00000000 0000020D
10011101 0040A000 00000000 2000A000 00000300
11011100 0040B000 DEADBEEF 00000000 0000020F
10011100 0040C000 00000000 00000000 0000020D
00011100 0040D000 00000000 00000000 0000020C
10111100 00400200 00000000 20000200 00000300
11011100 00400040 13579BDF 20000040 00000100
00011100 00401100 00000000 20001100 00000300
10011100 00402200 00000000 20002200 00000300
00011100 00403300 00000000 20003300 00000300
10011100 00404400 00000000 20004400 00000300
00011100 00405500 00000000 20005500 00000300
10011100 00406600 00000000 20006600 00000300
00011100 00407700 00000000 20007700 00000300
10011100 00404040 00000000 20004040 00000100
20011100 00405010 00000000 20005010 00000100
10011100 00400300 00000000 20000300 00000300

// File: mmu_top.sv
`default_nettype none

module mmu_top #(
   parameter int TLB_ENTRIES = 16
) (
   input  wire logic                  clk,
   input  wire logic                  rstn,
   input  wire mmu_bus_pkg::mmu_csr_t csr,
   input  wire logic                  flush_tlb,
   input  wire logic                  fetch_req,
   input  wire mmu_bus_pkg::cpu_cmd_t fetch_cmd,
   output logic                       fetch_ack,
   output mmu_bus_pkg::cpu_resp_t     fetch_resp,
   input  wire logic                  data_req,
   input  wire mmu_bus_pkg::cpu_cmd_t data_cmd,
   output logic                       data_ack,
   output mmu_bus_pkg::cpu_resp_t     data_resp,
   output logic                       bus_req,
   output mmu_bus_pkg::cpu_cmd_t      bus_cmd,
   input  wire logic                  bus_ack,
   input  wire sv32_pkg::mem_word_u   bus_rdata
);

   logic [19:0]                              lookup_vpn;
   logic                                     hit;
   sv32_pkg::tlb_entry_t                     hit_entry;
   logic                                     fill_valid;
   sv32_pkg::tlb_entry_t                     fill_entry;
   logic [TLB_ENTRIES-1:0]                   wr_en;
   sv32_pkg::tlb_entry_t                     wr_entry;
   logic                                     slot_flush;
   logic [TLB_ENTRIES-1:0]                   hit_vec;
   logic [TLB_ENTRIES-1:0]                   slot_valid;
   sv32_pkg::tlb_entry_t [TLB_ENTRIES-1:0]   slot_entries;

   page_walker u_walker (
      .clk        (clk),
      .rstn       (rstn),
      .csr        (csr),
      .fetch_req  (fetch_req),
      .fetch_cmd  (fetch_cmd),
      .fetch_ack  (fetch_ack),
      .fetch_resp (fetch_resp),
      .data_req   (data_req),
      .data_cmd   (data_cmd),
      .data_ack   (data_ack),
      .data_resp  (data_resp),
      .bus_req    (bus_req),
      .bus_cmd    (bus_cmd),
      .bus_ack    (bus_ack),
      .bus_rdata  (bus_rdata),
      .lookup_vpn (lookup_vpn),
      .hit        (hit),
      .hit_entry  (hit_entry),
      .fill_valid (fill_valid),
      .fill_entry (fill_entry)
   );

   tlb_refill #(.TLB_ENTRIES(TLB_ENTRIES)) u_refill (
      .clk        (clk),
      .rstn       (rstn),
      .fill_valid (fill_valid),
      .fill_entry (fill_entry),
      .flush_tlb  (flush_tlb),
      .slot_valid (slot_valid),
      .wr_en      (wr_en),
      .wr_entry   (wr_entry),
      .flush      (slot_flush)
   );

   // one slot per entry
   for (genvar g = 0; g < TLB_ENTRIES; g++) begin : g_slot
      tlb_entry u_slot (
         .clk        (clk),
         .rstn       (rstn),
         .wr_en      (wr_en[g]),
         .wr_entry   (wr_entry),
         .flush      (slot_flush),
         .lookup_vpn (lookup_vpn),
         .entry      (slot_entries[g]),
         .hit        (hit_vec[g])
      );
      assign slot_valid[g] = slot_entries[g].valid;
   end

   tlb_match #(.TLB_ENTRIES(TLB_ENTRIES)) u_match (
      .hit_vec (hit_vec),
      .entries (slot_entries),
      .hit     (hit),
      .entry   (hit_entry)
   );

endmodule

`default_nettype wire

// File: page_walker.sv
`default_nettype none

module page_walker (
   input  wire logic                  clk,
   input  wire logic                  rstn,
   input  wire mmu_bus_pkg::mmu_csr_t csr,
   input  wire logic                  fetch_req,
   input  wire mmu_bus_pkg::cpu_cmd_t fetch_cmd,
   output logic                       fetch_ack,
   output mmu_bus_pkg::cpu_resp_t     fetch_resp,
   input  wire logic                  data_req,
   input  wire mmu_bus_pkg::cpu_cmd_t data_cmd,
   output logic                       data_ack,
   output mmu_bus_pkg::cpu_resp_t     data_resp,
   output logic                       bus_req,
   output mmu_bus_pkg::cpu_cmd_t      bus_cmd,
   input  wire logic                  bus_ack,
   input  wire sv32_pkg::mem_word_u   bus_rdata,
   output logic [19:0]                lookup_vpn,
   input  wire logic                  hit,
   input  wire sv32_pkg::tlb_entry_t  hit_entry,
   output logic                       fill_valid,
   output sv32_pkg::tlb_entry_t       fill_entry
);

   typedef enum logic [2:0] {IDLE, L1_READ, L0_READ, ACCESS, RESPOND, RELEASE} state_e;

   state_e                 state;
   mmu_bus_pkg::cpu_cmd_t  cur_cmd;
   logic                   is_fetch_q;
   mmu_bus_pkg::priv_e     priv_q;
   mmu_bus_pkg::cpu_resp_t resp_q;

   logic                   sel_fetch;
   logic                   go;
   logic                   paging_on;
   mmu_bus_pkg::cpu_cmd_t  sel_cmd;
   mmu_bus_pkg::priv_e     sel_priv;
   sv32_pkg::vaddr_t       sel_va;
   sv32_pkg::vaddr_t       cur_va;
   sv32_pkg::pte_t         rd_pte;
   sv32_pkg::pte_t         chk_pte;
   logic                   chk_fetch;
   logic                   chk_write;
   mmu_bus_pkg::priv_e     chk_priv;
   logic [31:0]            chk_vaddr;
   logic                   chk_invalid;
   logic                   chk_leaf;
   logic                   chk_fault;
   logic [19:0]            leaf_ppn;
   logic                   bus_done;

   function automatic mmu_bus_pkg::cpu_resp_t fault_resp(input logic fetch,
                                                         input logic write,
                                                         input logic [31:0] va);
      mmu_bus_pkg::cpu_resp_t r;
      r.data     = '0;
      r.fault    = 1'b1;
      r.tval     = va;
      r.exc_code = fetch ? sv32_pkg::EXC_FETCH_PF :
                   write ? sv32_pkg::EXC_STORE_PF : sv32_pkg::EXC_LOAD_PF;
      return r;
   endfunction

   function automatic mmu_bus_pkg::cpu_cmd_t pte_read(input logic [31:0] addr);
      return '{write: 1'b0, addr: addr, wdata: '0, wstrb: '0};
   endfunction

   //////////////////////////////
   // arbitration and checks
   //////////////////////////////

   // fetch wins a tie
   assign sel_fetch  = fetch_req;
   assign go         = fetch_req || data_req;
   assign sel_cmd    = sel_fetch ? fetch_cmd : data_cmd;
   assign sel_priv   = sel_fetch ? csr.fetch_priv : csr.data_priv;
   assign sel_va     = sel_cmd.addr;
   assign cur_va     = cur_cmd.addr;
   assign paging_on  = csr.satp_mode && (sel_priv != mmu_bus_pkg::PRIV_M);
   assign lookup_vpn = sel_cmd.addr[31:sv32_pkg::PAGE_BITS];
   assign rd_pte     = bus_rdata.pte;
   assign bus_done   = bus_req && bus_ack;

   // idle checks the tlb hit, walk states check the word just read
   assign chk_pte   = (state == IDLE) ? sv32_pkg::pte_t'({2'b00, hit_entry.ppn, 2'b00,
                                                          hit_entry.flags}) : rd_pte;
   assign chk_fetch = (state == IDLE) ? sel_fetch : is_fetch_q;
   assign chk_write = (state == IDLE) ? (!sel_fetch && sel_cmd.write) :
                                        (!is_fetch_q && cur_cmd.write);
   assign chk_priv  = (state == IDLE) ? sel_priv : priv_q;
   assign chk_vaddr = (state == IDLE) ? sel_cmd.addr : cur_cmd.addr;

   // megapage keeps vpn0 from the virtual address
   assign leaf_ppn = (state == L1_READ) ? {rd_pte.ppn1[9:0], cur_va.vpn0} :
                                          {rd_pte.ppn1[9:0], rd_pte.ppn0};

   pte_check u_pte_check (
      .pte      (chk_pte),
      .level    (state == L1_READ),
      .is_fetch (chk_fetch),
      .is_write (chk_write),
      .priv     (chk_priv),
      .sum      (csr.sum),
      .mxr      (csr.mxr),
      .invalid  (chk_invalid),
      .leaf     (chk_leaf),
      .fault    (chk_fault)
   );

   assign fetch_resp = resp_q;
   assign data_resp  = resp_q;

   //////////////////////////////
   // translation FSM
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         state      <= IDLE;
         fetch_ack  <= 1'b0;
         data_ack   <= 1'b0;
         bus_req    <= 1'b0;
         fill_valid <= 1'b0;
      end else begin
         fill_valid <= 1'b0;
         // raise bus_req once the previous ack is gone
         if (state inside {L1_READ, L0_READ, ACCESS}) begin
            if (!bus_req && !bus_ack) bus_req <= 1'b1;
            if (bus_done) bus_req <= 1'b0;
         end
         case (state)
            IDLE: begin
               if (go) begin
                  cur_cmd    <= sel_cmd;
                  is_fetch_q <= sel_fetch;
                  priv_q     <= sel_priv;
                  if (!paging_on) begin
                     bus_cmd <= sel_cmd;
                     state   <= ACCESS;
                  end else if (hit && chk_fault) begin
                     resp_q <= fault_resp(chk_fetch, chk_write, chk_vaddr);
                     state  <= RESPOND;
                  end else if (hit) begin
                     bus_cmd      <= sel_cmd;
                     bus_cmd.addr <= {hit_entry.ppn, sel_va.offset};
                     state        <= ACCESS;
                  end else begin
                     bus_cmd <= pte_read({csr.satp_ppn[19:0], sel_va.vpn1, 2'b00});
                     state   <= L1_READ;
                  end
               end
            end
            L1_READ, L0_READ: begin
               if (bus_done) begin
                  if (chk_invalid || (chk_leaf && chk_fault) ||
                      (!chk_leaf && state == L0_READ)) begin
                     resp_q <= fault_resp(chk_fetch, chk_write, chk_vaddr);
                     state  <= RESPOND;
                  end else if (chk_leaf) begin
                     fill_valid   <= 1'b1;
                     fill_entry   <= '{valid: 1'b1, tag: cur_cmd.addr[31:12],
                                       ppn: leaf_ppn, flags: rd_pte[7:0]};
                     bus_cmd      <= cur_cmd;
                     bus_cmd.addr <= {leaf_ppn, cur_va.offset};
                     state        <= ACCESS;
                  end else begin
                     // upper two ppn bits dropped
                     bus_cmd <= pte_read({rd_pte.ppn1[9:0], rd_pte.ppn0, cur_va.vpn0, 2'b00});
                     state   <= L0_READ;
                  end
               end
            end
            ACCESS: begin
               if (bus_done) begin
                  resp_q <= '{data: bus_rdata.data, fault: 1'b0, exc_code: '0, tval: '0};
                  state  <= RESPOND;
               end
            end
            RESPOND: begin
               fetch_ack <= is_fetch_q;
               data_ack  <= !is_fetch_q;
               state     <= RELEASE;
            end
            RELEASE: begin
               if (is_fetch_q ? !fetch_req : !data_req) begin
                  fetch_ack <= 1'b0;
                  data_ack  <= 1'b0;
                  state     <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: pte_check.sv
`default_nettype none

module pte_check (
   input  wire sv32_pkg::pte_t      pte,
   input  wire logic                level,
   input  wire logic                is_fetch,
   input  wire logic                is_write,
   input  wire mmu_bus_pkg::priv_e  priv,
   input  wire logic                sum,
   input  wire logic                mxr,
   output logic                     invalid,
   output logic                     leaf,
   output logic                     fault
);

   logic is_read;
   logic readable;

   assign invalid  = !pte.v || (pte.w && !pte.r);
   assign leaf     = pte.r || pte.x;
   assign is_read  = !is_fetch && !is_write;
   // mxr lets loads use execute-only pages
   assign readable = pte.r || (mxr && pte.x);

   always_comb begin
      fault = 1'b0;
      // megapage must be 4 MiB aligned
      if (level && (pte.ppn0 != '0)) fault = 1'b1;
      if (!pte.u && (priv == mmu_bus_pkg::PRIV_U)) fault = 1'b1;
      if (pte.u && (priv == mmu_bus_pkg::PRIV_S) && !sum) fault = 1'b1;
      if (is_fetch && !pte.x) fault = 1'b1;
      if (is_read && !readable) fault = 1'b1;
      if (is_write && !pte.w) fault = 1'b1;
      // no hardware A/D update
      if (!pte.a) fault = 1'b1;
      if (is_write && !pte.d) fault = 1'b1;
   end

endmodule

`default_nettype wire

// File: sv32_pkg.sv
`default_nettype none

package sv32_pkg;

   localparam int PAGE_BITS = 12;

   // page fault causes
   localparam logic [4:0] EXC_FETCH_PF = 5'd12;
   localparam logic [4:0] EXC_LOAD_PF  = 5'd13;
   localparam logic [4:0] EXC_STORE_PF = 5'd15;

   typedef struct packed {
      logic [9:0]  vpn1;
      logic [9:0]  vpn0;
      logic [11:0] offset;
   } vaddr_t;

   typedef struct packed {
      logic [11:0] ppn1;
      logic [9:0]  ppn0;
      logic [1:0]  rsw;
      logic        d;
      logic        a;
      logic        g;
      logic        u;
      logic        x;
      logic        w;
      logic        r;
      logic        v;
   } pte_t;

   // a PTE during the walk, plain data on the final access
   typedef union packed {
      pte_t        pte;
      logic [31:0] data;
   } mem_word_u;

   // flags are pte bits 7..0
   typedef struct packed {
      logic        valid;
      logic [19:0] tag;
      logic [19:0] ppn;
      logic [7:0]  flags;
   } tlb_entry_t;

endpackage

`default_nettype wire

// File: tb_checker.sv
`default_nettype none

module tb_checker #(
   parameter logic [31:0] FILL_KEY = 32'h5a5a5a5a
) (
   input  wire logic                   clk,
   input  wire logic                   rstn,
   input  wire logic                   fetch_ack,
   input  wire mmu_bus_pkg::cpu_resp_t fetch_resp,
   input  wire logic                   data_ack,
   input  wire mmu_bus_pkg::cpu_resp_t data_resp,
   input  wire logic                   bus_req,
   input  wire logic                   bus_ack,
   input  wire mmu_bus_pkg::cpu_cmd_t  bus_cmd,
   input  wire logic                   exp_push,
   input  wire logic                   exp_fetch,
   input  wire logic                   exp_write,
   input  wire logic [31:0]            exp_vaddr,
   input  wire logic [31:0]            exp_wdata,
   input  wire logic [31:0]            exp_paddr,
   input  wire logic [4:0]             exp_code,
   input  wire logic [7:0]             exp_trans,
   input  wire logic                   done,
   output int                          value_errs,
   output int                          other_errs
);

   typedef struct packed {
      logic        fetch;
      logic        write;
      logic [31:0] vaddr;
      logic [31:0] wdata;
      logic [31:0] paddr;
      logic [4:0]  code;
      logic [7:0]  trans;
   } expect_t;

   expect_t     pending[$];
   int          n_trans;
   logic [31:0] last_addr;
   logic        last_write;
   logic        bus_ack_q;
   logic        fetch_ack_q;
   logic        data_ack_q;
   logic        done_q;

   task automatic report_fail(input string msg);
      value_errs++;
      $display("Fail %0t: %s", $time, msg);
   endtask

   task automatic compare(input logic is_fetch, input mmu_bus_pkg::cpu_resp_t resp);
      expect_t e;
      if (pending.size() == 0) begin
         other_errs++;
         $display("an ack came with no request outstanding at time %0t", $time);
         return;
      end
      e = pending.pop_front();
      if (e.fetch != is_fetch)
         report_fail($sformatf("va %h answered on the wrong port", e.vaddr));
      if (n_trans != e.trans)
         report_fail($sformatf("va %h took %0d bus transactions, expected %0d",
                               e.vaddr, n_trans, e.trans));
      if (e.code == 5'd0) begin
         if (resp.fault)
            report_fail($sformatf("va %h faulted with code %0d", e.vaddr, resp.exc_code));
         if (last_addr != e.paddr)
            report_fail($sformatf("va %h went to pa %h, expected %h", e.vaddr, last_addr,
                                  e.paddr));
         if (last_write != e.write)
            report_fail($sformatf("va %h bus access write %0b, expected %0b", e.vaddr,
                                  last_write, e.write));
         if (resp.data != (e.paddr ^ FILL_KEY))
            report_fail($sformatf("va %h returned data %h", e.vaddr, resp.data));
      end else begin
         if (!resp.fault || resp.exc_code != e.code)
            report_fail($sformatf("va %h gave fault %0b code %0d, expected code %0d",
                                  e.vaddr, resp.fault, resp.exc_code, e.code));
         if (resp.tval != e.vaddr || resp.data != 32'd0)
            report_fail($sformatf("va %h fault gave tval %h data %h", e.vaddr, resp.tval,
                                  resp.data));
      end
      n_trans = 0;
   endtask

   initial begin
      value_errs = 0;
      other_errs = 0;
      n_trans    = 0;
      last_addr  = '0;
      last_write = 1'b0;
   end

   always @(posedge clk) begin
      if (rstn) begin
         bus_ack_q   <= 1'b0;
         fetch_ack_q <= 1'b0;
         data_ack_q  <= 1'b0;
         done_q      <= 1'b0;
      end else begin
         if (exp_push)
            pending.push_back('{exp_fetch, exp_write, exp_vaddr, exp_wdata, exp_paddr,
                                exp_code, exp_trans});
         // one transaction per rising bus_ack
         if (bus_req && bus_ack && !bus_ack_q) begin
            n_trans++;
            last_addr  = bus_cmd.addr;
            last_write = bus_cmd.write;
            if (bus_cmd.write && pending.size() > 0 &&
                (bus_cmd.wdata != pending[0].wdata || bus_cmd.wstrb != 4'hf))
               report_fail($sformatf("store data %h strobes %h on the bus", bus_cmd.wdata,
                                     bus_cmd.wstrb));
         end
         if (fetch_ack && !fetch_ack_q) compare(1'b1, fetch_resp);
         if (data_ack && !data_ack_q) compare(1'b0, data_resp);
         bus_ack_q   <= bus_ack;
         fetch_ack_q <= fetch_ack;
         data_ack_q  <= data_ack;
         done_q      <= done;
         if (done && !done_q) begin
            if (pending.size() > 0) begin
               other_errs += pending.size();
               $display("%0d request(s) were never answered", pending.size());
            end
            $display("errors: %0d wrong values, %0d other", value_errs, other_errs);
         end
      end
   end

endmodule

`default_nettype wire

// File: tb_mmu.sv
`default_nettype none

module tb_mmu;

   localparam int          TLB_SLOTS  = 4;
   localparam logic [31:0] FILL_KEY   = 32'h5a5a5a5a;
   localparam logic [31:0] LFSR_SEED  = 32'hbb12c400;
   localparam int          CYCLES_PER = 200;
   localparam int          PERIOD     = 40;

   logic                   clk;
   logic                   rstn;
   mmu_bus_pkg::mmu_csr_t  csr;
   logic                   flush_tlb;
   logic                   fetch_req;
   mmu_bus_pkg::cpu_cmd_t  fetch_cmd;
   logic                   fetch_ack;
   mmu_bus_pkg::cpu_resp_t fetch_resp;
   logic                   data_req;
   mmu_bus_pkg::cpu_cmd_t  data_cmd;
   logic                   data_ack;
   mmu_bus_pkg::cpu_resp_t data_resp;
   logic                   bus_req;
   mmu_bus_pkg::cpu_cmd_t  bus_cmd;
   logic                   bus_ack;
   sv32_pkg::mem_word_u    bus_rdata;

   logic                   exp_push;
   logic                   exp_fetch;
   logic                   exp_write;
   logic [31:0]            exp_vaddr;
   logic [31:0]            exp_wdata;
   logic [31:0]            exp_paddr;
   logic [4:0]             exp_code;
   logic [7:0]             exp_trans;
   logic                   done;
   int                     value_errs;
   int                     other_errs;

   logic [31:0]            tdata [0:255];
   logic [31:0]            pt_addr[$];
   logic [31:0]            pt_word[$];
   int                     req_base;
   int                     nreq;
   logic                   loaded;
   logic [31:0]            lfsr;
   int                     delay;
   logic                   waiting;

   mmu_top #(.TLB_ENTRIES(TLB_SLOTS)) UUT (
      .clk        (clk),
      .rstn       (rstn),
      .csr        (csr),
      .flush_tlb  (flush_tlb),
      .fetch_req  (fetch_req),
      .fetch_cmd  (fetch_cmd),
      .fetch_ack  (fetch_ack),
      .fetch_resp (fetch_resp),
      .data_req   (data_req),
      .data_cmd   (data_cmd),
      .data_ack   (data_ack),
      .data_resp  (data_resp),
      .bus_req    (bus_req),
      .bus_cmd    (bus_cmd),
      .bus_ack    (bus_ack),
      .bus_rdata  (bus_rdata)
   );

   tb_checker #(.FILL_KEY(FILL_KEY)) u_checker (
      .clk        (clk),
      .rstn       (rstn),
      .fetch_ack  (fetch_ack),
      .fetch_resp (fetch_resp),
      .data_ack   (data_ack),
      .data_resp  (data_resp),
      .bus_req    (bus_req),
      .bus_ack    (bus_ack),
      .bus_cmd    (bus_cmd),
      .exp_push   (exp_push),
      .exp_fetch  (exp_fetch),
      .exp_write  (exp_write),
      .exp_vaddr  (exp_vaddr),
      .exp_wdata  (exp_wdata),
      .exp_paddr  (exp_paddr),
      .exp_code   (exp_code),
      .exp_trans  (exp_trans),
      .done       (done),
      .value_errs (value_errs),
      .other_errs (other_errs)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   ////////////////////////////////
   // memory model
   ////////////////////////////////

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic lsb;
      lsb = s[0];
      s   = s >> 1;
      if (lsb) s = s ^ 32'h80200003;
      return s;
   endfunction

   function automatic logic [31:0] read_word(input logic [31:0] addr);
      for (int i = 0; i < pt_addr.size(); i++) begin
         if (pt_addr[i] == addr) return pt_word[i];
      end
      return addr ^ FILL_KEY;
   endfunction

   always @(posedge clk) begin
      if (rstn) begin
         bus_ack <= 1'b0;
         waiting = 1'b0;
      end else if (bus_ack) begin
         if (!bus_req) bus_ack <= 1'b0;
      end else if (bus_req) begin
         if (!waiting) begin
            // two lfsr bits give 0 to 3 wait cycles
            delay = lfsr[0];
            lfsr  = lfsr_step(lfsr);
            delay = delay + 2 * lfsr[0];
            lfsr  = lfsr_step(lfsr);
            waiting = 1'b1;
         end
         if (delay == 0) begin
            bus_ack        <= 1'b1;
            bus_rdata.data <= read_word(bus_cmd.addr);
            waiting = 1'b0;
         end else begin
            delay = delay - 1;
         end
      end
   end

   ////////////////////////////////
   // stimulus
   ////////////////////////////////

   function automatic logic [31:0] field(input int r, input int k);
      return tdata[req_base + 5 * r + k];
   endfunction

   task automatic push_expect(input int r, input logic is_fetch);
      logic [31:0] ctrl;
      logic [31:0] outcome;
      ctrl    = field(r, 0);
      outcome = field(r, 4);
      @(posedge clk);
      exp_push  <= 1'b1;
      exp_fetch <= is_fetch;
      exp_write <= ctrl[24];
      exp_vaddr <= field(r, 1);
      exp_wdata <= field(r, 2);
      exp_paddr <= field(r, 3);
      exp_code  <= outcome[4:0];
      exp_trans <= outcome[15:8];
      csr       <= '{satp_mode: ctrl[16], satp_ppn: tdata[0][21:0],
                     fetch_priv: mmu_bus_pkg::priv_e'(ctrl[13:12]),
                     data_priv: mmu_bus_pkg::priv_e'(ctrl[9:8]),
                     sum: ctrl[4], mxr: ctrl[0]};
      @(posedge clk);
      exp_push <= 1'b0;
      if (ctrl[20]) begin
         flush_tlb <= 1'b1;
         @(posedge clk);
         flush_tlb <= 1'b0;
      end
   endtask

   // full four-phase cycle on one cpu port
   task automatic drive_request(input int r, input logic is_fetch);
      mmu_bus_pkg::cpu_cmd_t cmd;
      logic [31:0]           ctrl;
      ctrl = field(r, 0);
      cmd  = '{write: ctrl[24], addr: field(r, 1), wdata: field(r, 2), wstrb: 4'hf};
      @(posedge clk);
      if (is_fetch) begin
         fetch_cmd <= cmd;
         fetch_req <= 1'b1;
         while (!fetch_ack) @(posedge clk);
         fetch_req <= 1'b0;
         while (fetch_ack) @(posedge clk);
      end else begin
         data_cmd <= cmd;
         data_req <= 1'b1;
         while (!data_ack) @(posedge clk);
         data_req <= 1'b0;
         while (data_ack) @(posedge clk);
      end
   endtask

   initial begin
      int          r;
      int          npt;
      logic [31:0] ctrl;
      rstn      = 1'b1;
      csr       = '0;
      flush_tlb = 1'b0;
      fetch_req = 1'b0;
      fetch_cmd = '0;
      data_req  = 1'b0;
      data_cmd  = '0;
      bus_ack   = 1'b0;
      bus_rdata = '0;
      exp_push  = 1'b0;
      exp_fetch = 1'b0;
      exp_write = 1'b0;
      exp_vaddr = '0;
      exp_wdata = '0;
      exp_paddr = '0;
      exp_code  = '0;
      exp_trans = '0;
      done      = 1'b0;
      lfsr      = LFSR_SEED;
      loaded    = 1'b0;
      $readmemh("mmu_testdata.txt", tdata);
      npt = tdata[1];
      for (int i = 0; i < npt; i++) begin
         pt_addr.push_back(tdata[2 + 2 * i]);
         pt_word.push_back(tdata[3 + 2 * i]);
      end
      nreq     = tdata[2 + 2 * npt];
      req_base = 3 + 2 * npt;
      loaded   = 1'b1;
      repeat (2) @(posedge clk);
      rstn <= 1'b0;
      r = 0;
      while (r < nreq) begin
         ctrl = field(r, 0);
         // port 2 pairs a fetch with the next data request
         if (ctrl[31:28] == 4'd2) begin
            push_expect(r, 1'b1);
            push_expect(r + 1, 1'b0);
            fork
               drive_request(r, 1'b1);
               drive_request(r + 1, 1'b0);
            join
            r = r + 2;
         end else begin
            push_expect(r, ctrl[31:28] == 4'd0);
            drive_request(r, ctrl[31:28] == 4'd0);
            r = r + 1;
         end
      end
      repeat (4) @(posedge clk);
      done <= 1'b1;
      repeat (2) @(posedge clk);
      if (value_errs == 0 && other_errs == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // watchdog
   initial begin
      wait (loaded);
      #(nreq * CYCLES_PER * PERIOD);
      $display("timeout: the requests did not finish in time");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// File: tlb_entry.sv
`default_nettype none

module tlb_entry (
   input  wire logic                 clk,
   input  wire logic                 rstn,
   input  wire logic                 wr_en,
   input  wire sv32_pkg::tlb_entry_t wr_entry,
   input  wire logic                 flush,
   input  wire logic [19:0]          lookup_vpn,
   output sv32_pkg::tlb_entry_t      entry,
   output logic                      hit
);

   // flush beats a write in the same cycle
   always_ff @(posedge clk) begin
      if (rstn || flush) begin
         entry.valid <= 1'b0;
      end else if (wr_en) begin
         entry <= wr_entry;
      end
   end

   assign hit = entry.valid && (entry.tag == lookup_vpn);

endmodule

`default_nettype wire

// File: tlb_match.sv
`default_nettype none

module tlb_match #(
   parameter int TLB_ENTRIES = 16
) (
   input  wire logic [TLB_ENTRIES-1:0]                 hit_vec,
   input  wire sv32_pkg::tlb_entry_t [TLB_ENTRIES-1:0] entries,
   output logic                                        hit,
   output sv32_pkg::tlb_entry_t                        entry
);

   assign hit = |hit_vec;

   // tags are unique, lowest index wins anyway
   always_comb begin
      entry = '0;
      for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
         if (hit_vec[i]) begin
            entry = entries[i];
         end
      end
   end

endmodule

`default_nettype wire

// File: tlb_refill.sv
`default_nettype none

module tlb_refill #(
   parameter int TLB_ENTRIES = 16
) (
   input  wire logic                   clk,
   input  wire logic                   rstn,
   input  wire logic                   fill_valid,
   input  wire sv32_pkg::tlb_entry_t   fill_entry,
   input  wire logic                   flush_tlb,
   input  wire logic [TLB_ENTRIES-1:0] slot_valid,
   output logic [TLB_ENTRIES-1:0]      wr_en,
   output sv32_pkg::tlb_entry_t        wr_entry,
   output logic                        flush
);

   localparam int PTR_BITS = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

   logic [PTR_BITS-1:0] rr_ptr;
   logic [PTR_BITS-1:0] free_idx;
   logic [PTR_BITS-1:0] victim;
   logic                any_free;
   logic                do_fill;

   // lowest free slot
   always_comb begin
      free_idx = '0;
      any_free = 1'b0;
      for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
         if (!slot_valid[i]) begin
            free_idx = PTR_BITS'(i);
            any_free = 1'b1;
         end
      end
   end

   assign do_fill = fill_valid && !flush_tlb;
   assign victim  = any_free ? free_idx : rr_ptr;

   always_comb begin
      wr_en         = '0;
      wr_en[victim] = do_fill;
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         rr_ptr <= '0;
      end else if (do_fill && !any_free) begin
         if (rr_ptr == PTR_BITS'(TLB_ENTRIES - 1)) begin
            rr_ptr <= '0;
         end else begin
            rr_ptr <= rr_ptr + 1'b1;
         end
      end
   end

   always_comb begin
      wr_entry       = fill_entry;
      wr_entry.valid = 1'b1;
   end

   assign flush = flush_tlb;

endmodule

`default_nettype wire

// File: vlog.f
sv32_pkg.sv
mmu_bus_pkg.sv
tlb_entry.sv
tlb_refill.sv
tlb_match.sv
pte_check.sv
page_walker.sv
mmu_top.sv
tb_checker.sv
tb_mmu.sv
